/* bench/exu_input.txt */
# op alu_mode inst pc operand_a operand_b | reg_wen reg_idx reg_wdata pc_update dnpc
# all hex, x in an operand column is filled with a random value
d 0 300022f3 80000000 0 0 1 05 0000000a00001800 1 80000004
1 0 00c58533 80000004 7fffffffffffffff 1 1 0a 8000000000000000 1 80000008
1 1 40c58533 80000008 5 7 1 0a fffffffffffffffe 1 8000000c
1 2 00c5a533 8000000c ffffffffffffffff 1 1 0a 1 1 80000010
1 3 00c5b533 80000010 ffffffffffffffff 1 1 0a 0 1 80000014
1 4 00c5f533 80000014 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 1 0a f000f000f000f000 1 80000018
1 6 00c5e533 80000018 f0f0f0f0f0f0f0f0 0f0f00000000ffff 1 0a fffff0f0f0f0ffff 1 8000001c
1 7 00c5c533 8000001c aaaaaaaaaaaaaaaa ffffffff00000000 1 0a 55555555aaaaaaaa 1 80000020
1 8 00c59533 80000020 1 7f 1 0a 8000000000000000 1 80000024
1 9 00c5d533 80000024 8000000000000000 4 1 0a 0800000000000000 1 80000028
1 a 40c5d533 80000028 8000000000000000 4 1 0a f800000000000000 1 8000002c
2 0 00c5853b 8000002c 7fffffff 1 1 0a ffffffff80000000 1 80000030
3 0 123452b7 80000030 x x 1 05 0000000012345000 1 80000034
4 0 100000ef 80000034 80000034 100 1 01 80000038 1 80000134
5 0 011280e7 80000134 80001000 11 1 01 80000138 1 80001010
6 1 04c58063 80000200 5 5 0 00 0 1 80000240
6 1 04c58063 80000204 5 6 0 00 0 1 80000208
7 1 fec598e3 80000208 1 2 0 11 0 1 800001f8
7 1 04c59063 8000020c 9 9 0 00 0 1 80000210
8 2 04c5c063 80000210 ffffffffffffffff 0 0 00 0 1 80000250
8 2 04c5c063 80000214 3 2 0 00 0 1 80000218
9 2 04c5d063 80000218 3 ffffffffffffffff 0 00 0 1 80000258
9 2 04c5d063 8000021c ffffffffffffff00 1 0 00 0 1 80000220
a 3 04c5e063 80000220 1 ffffffffffffffff 0 00 0 1 80000260
a 3 04c5e063 80000224 ffffffffffffffff 1 0 00 0 1 80000228
b 3 04c5f063 80000228 ffffffffffffffff 1 0 00 0 1 80000268
b 3 04c5f063 8000022c 1 2 0 00 0 1 80000230
c 0 30539373 80000300 80000100 0 1 06 0 1 80000304
d 0 3053a373 80000304 c 0 1 06 80000100 1 80000308
d 0 30502373 80000308 0 0 1 06 8000010c 1 8000030c
e 0 00000073 80000400 x x 0 00 0 1 8000010c
d 0 34102473 8000010c 0 0 1 08 80000400 1 80000110
d 0 342024f3 80000110 0 0 1 09 b 1 80000114
f 0 30200073 80000114 x x 0 00 0 1 80000400

/* bench/exu_tb.sv */
module exu_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int CHECK_DELAY  = 90;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_VEC      = 64;
    localparam VEC_FILE         = "bench/exu_input.txt";

    logic                     clk;
    logic                     rst;
    exu_ctrl_pkg::exu_op_e    op;
    exu_ctrl_pkg::alu_mode_e  alu_mode;
    riscv_isa_pkg::inst_t     inst;
    riscv_isa_pkg::xlen_t     pc;
    riscv_isa_pkg::xlen_t     operand_a;
    riscv_isa_pkg::xlen_t     operand_b;
    riscv_isa_pkg::xlen_t     dnpc;
    riscv_isa_pkg::xlen_t     pc_wb;
    riscv_isa_pkg::xlen_t     reg_wdata;
    riscv_isa_pkg::inst_t     inst_wb;
    logic                     pc_update;
    logic                     reg_wen;
    riscv_isa_pkg::reg_idx_t  reg_idx;

    // vector table, eleven hex columns per row
    logic [63:0] vec_data [MAX_VEC][11];
    int          vec_line [MAX_VEC];
    int          vec_count   = 0;
    int          errors      = 0;
    int          checks      = 0;
    int          cycles      = 0;
    int          cycle_limit = 1000;

    exu_top i_exu_top (
        .clk(clk), .rst(rst), .op(op), .alu_mode(alu_mode), .inst(inst),
        .pc(pc), .operand_a(operand_a), .operand_b(operand_b),
        .dnpc(dnpc), .pc_wb(pc_wb), .reg_wdata(reg_wdata), .inst_wb(inst_wb),
        .pc_update(pc_update), .reg_wen(reg_wen), .reg_idx(reg_idx)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ******************************************************************
    // run guard, limit set once the vectors are known
    // ******************************************************************
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("run stopped, no result after %0d cycles", cycle_limit);
            $display("tests failed");
            $finish;
        end
    end

    task automatic check_value(string test, string field, logic [63:0] expected,
                               logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("[ERROR] %s %s: expected %h, actual %h", test, field, expected, actual);
        end
    endtask

    // x in an operand column means any value will do
    function automatic riscv_isa_pkg::xlen_t fill_dont_care(logic [63:0] value);
        if ($isunknown(value))
            return {$urandom(), $urandom()};
        return value;
    endfunction

    task automatic load_vectors();
        int          fd;
        int          line_no;
        int          got;
        int          c;
        string       text;
        logic [63:0] f [11];
        line_no = 0;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("could not open the vector file %s", VEC_FILE);
            errors++;
            return;
        end
        while ($fgets(text, fd) != 0) begin
            line_no++;
            // column notes and blank lines
            if (text.len() < 2 || text.getc(0) == "#")
                continue;
            got = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                          f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
            if (got != 11 || vec_count == MAX_VEC) begin
                $display("line %0d of %s is not a usable vector", line_no, VEC_FILE);
                errors++;
            end else begin
                for (c = 0; c < 11; c++)
                    vec_data[vec_count][c] = f[c];
                vec_line[vec_count] = line_no;
                vec_count++;
            end
        end
        $fclose(fd);
        if (vec_count == 0) begin
            $display("the vector file holds no vectors");
            errors++;
        end
    endtask

    task automatic drive_vector(int k);
        op        = exu_ctrl_pkg::exu_op_e'(vec_data[k][0][4:0]);
        alu_mode  = exu_ctrl_pkg::alu_mode_e'(vec_data[k][1][7:0]);
        inst      = vec_data[k][2][31:0];
        pc        = vec_data[k][3];
        operand_a = fill_dont_care(vec_data[k][4]);
        operand_b = fill_dont_care(vec_data[k][5]);
    endtask

    task automatic compare_outputs(int k);
        exu_ctrl_pkg::exu_op_e vec_op;
        string                 name;
        vec_op = exu_ctrl_pkg::exu_op_e'(vec_data[k][0][4:0]);
        name   = $sformatf("%s line %0d", vec_op.name(), vec_line[k]);
        check_value(name, "reg_wen", vec_data[k][6], reg_wen);
        // index only means something with a write
        if (vec_data[k][6] != 0)
            check_value(name, "reg_idx", vec_data[k][7], reg_idx);
        check_value(name, "reg_wdata", vec_data[k][8], reg_wdata);
        check_value(name, "pc_update", vec_data[k][9], pc_update);
        check_value(name, "dnpc", vec_data[k][10], dnpc);
        // pc and inst pass the stage untouched
        check_value(name, "pc_wb", pc, pc_wb);
        check_value(name, "inst_wb", inst, inst_wb);
    endtask

    initial begin
        void'($urandom(85));
        clk       = 1'b0;
        rst       = 1'b1;
        // a live op at the inputs, reset alone keeps the stage empty
        op        = exu_ctrl_pkg::OP_ALU;
        alu_mode  = exu_ctrl_pkg::ALU_ADD;
        inst      = '0;
        pc        = '0;
        operand_a = '0;
        operand_b = '0;
        load_vectors();
        // reset, one cycle out of reset, two cycles per vector, margin
        cycle_limit = RESET_CYCLES + 2 * vec_count + 20;

        // stage stays empty in reset and the cycle after
        for (int i = 1; i <= RESET_CYCLES; i++) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            if (i == RESET_CYCLES) begin
                rst = 1'b0;
                op  = exu_ctrl_pkg::OP_NONE;
            end
            #(CHECK_DELAY - DRIVE_DELAY);
            check_value("reset", "pc_update", '0, pc_update);
            check_value("reset", "reg_wen", '0, reg_wen);
        end

        // vector, then an empty slot so csr writes settle
        for (int k = 0; k < vec_count; k++) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            drive_vector(k);
            @(posedge clk);
            #(DRIVE_DELAY);
            op = exu_ctrl_pkg::OP_NONE;
            #(CHECK_DELAY - DRIVE_DELAY);
            compare_outputs(k);
        end

        $display("%0d errors in %0d checks over %0d vectors", errors, checks, vec_count);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* exu_lite.f */
logic/riscv_isa_pkg.sv
logic/exu_ctrl_pkg.sv
logic/exu_issue_reg.sv
logic/exu_alu.sv
logic/exu_branch.sv
logic/exu_csr_file.sv
logic/exu_writeback.sv
logic/exu_top.sv
bench/exu_tb.sv

/* logic/exu_alu.sv */
module exu_alu (
    input  exu_ctrl_pkg::alu_mode_e alu_mode,
    input  riscv_isa_pkg::xlen_t    operand_a,
    input  riscv_isa_pkg::xlen_t    operand_b,
    output riscv_isa_pkg::xlen_t    result
);

    logic [5:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // rv64 shifts use six bits of b
    assign shamt = operand_b[5:0];

    assign lt_signed   = $signed(operand_a) < $signed(operand_b);
    assign lt_unsigned = operand_a < operand_b;

    // ******************************************************************
    // function select
    // ******************************************************************
    always_comb begin
        case (alu_mode)
            exu_ctrl_pkg::ALU_ADD:
                result = operand_a + operand_b;
            exu_ctrl_pkg::ALU_SUB:
                result = operand_a - operand_b;
            // set-less-than, zero extended flag
            exu_ctrl_pkg::ALU_SLT:
                result = riscv_isa_pkg::xlen_t'(lt_signed);
            exu_ctrl_pkg::ALU_SLTU:
                result = riscv_isa_pkg::xlen_t'(lt_unsigned);
            exu_ctrl_pkg::ALU_AND:
                result = operand_a & operand_b;
            exu_ctrl_pkg::ALU_OR:
                result = operand_a | operand_b;
            exu_ctrl_pkg::ALU_XOR:
                result = operand_a ^ operand_b;
            exu_ctrl_pkg::ALU_SLL:
                result = operand_a << shamt;
            exu_ctrl_pkg::ALU_SRL:
                result = operand_a >> shamt;
            // keep sign bit on the way down
            exu_ctrl_pkg::ALU_SRA:
                result = riscv_isa_pkg::xlen_t'($signed(operand_a) >>> shamt);
            // unused codes read as zero
            default:
                result = '0;
        endcase
    end

endmodule

/* logic/exu_branch.sv */
module exu_branch (
    input  exu_ctrl_pkg::exu_op_e op,
    input  riscv_isa_pkg::xlen_t  pc,
    input  riscv_isa_pkg::xlen_t  imm_b,
    input  riscv_isa_pkg::xlen_t  alu_result,
    input  riscv_isa_pkg::xlen_t  mtvec,
    input  riscv_isa_pkg::xlen_t  mepc,
    output riscv_isa_pkg::xlen_t  dnpc,
    output logic                  pc_update
);

    riscv_isa_pkg::xlen_t snpc;
    riscv_isa_pkg::xlen_t btarget;
    logic                 res_zero;

    assign snpc     = pc + riscv_isa_pkg::INST_BYTES;
    assign btarget  = pc + imm_b;
    // decoder already chose sub / slt / sltu for the compare
    assign res_zero = alu_result == '0;

    always_comb begin
        case (op)
            exu_ctrl_pkg::OP_JAL:   dnpc = alu_result;
            // jalr target is halfword aligned
            exu_ctrl_pkg::OP_JALR:  dnpc = {alu_result[63:1], 1'b0};
            // beq/bge/bgeu on zero, the rest on nonzero
            exu_ctrl_pkg::OP_BEQ:   dnpc = res_zero ? btarget : snpc;
            exu_ctrl_pkg::OP_BNE:   dnpc = !res_zero ? btarget : snpc;
            exu_ctrl_pkg::OP_BLT:   dnpc = !res_zero ? btarget : snpc;
            exu_ctrl_pkg::OP_BGE:   dnpc = res_zero ? btarget : snpc;
            exu_ctrl_pkg::OP_BLTU:  dnpc = !res_zero ? btarget : snpc;
            exu_ctrl_pkg::OP_BGEU:  dnpc = res_zero ? btarget : snpc;
            // trap entry and return
            exu_ctrl_pkg::OP_ECALL: dnpc = mtvec;
            exu_ctrl_pkg::OP_MRET:  dnpc = mepc;
            default:                dnpc = snpc;
        endcase
    end

    assign pc_update = op != exu_ctrl_pkg::OP_NONE;

endmodule

/* logic/exu_csr_file.sv */
module exu_csr_file #(
    parameter riscv_isa_pkg::xlen_t MSTATUS_INIT = riscv_isa_pkg::MSTATUS_RESET
) (
    input  logic                      clk,
    input  logic                      rst,
    input  exu_ctrl_pkg::exu_op_e     op,
    input  riscv_isa_pkg::csr_addr_t  csr_addr,
    input  riscv_isa_pkg::xlen_t      pc,
    input  riscv_isa_pkg::xlen_t      operand_a,
    output riscv_isa_pkg::xlen_t      csr_rdata,
    output riscv_isa_pkg::xlen_t      mtvec,
    output riscv_isa_pkg::xlen_t      mepc
);

    riscv_isa_pkg::xlen_t mcause;
    riscv_isa_pkg::xlen_t mstatus;
    riscv_isa_pkg::xlen_t csr_wdata;
    logic                 csr_write;
    logic                 is_ecall;

    // ******************************************************************
    // read side, value before this instruction's write
    // ******************************************************************
    always_comb begin
        case (csr_addr)
            riscv_isa_pkg::CSR_MSTATUS: csr_rdata = mstatus;
            riscv_isa_pkg::CSR_MTVEC:   csr_rdata = mtvec;
            riscv_isa_pkg::CSR_MEPC:    csr_rdata = mepc;
            riscv_isa_pkg::CSR_MCAUSE:  csr_rdata = mcause;
            default:                    csr_rdata = '0;
        endcase
    end

    assign csr_write = op == exu_ctrl_pkg::OP_CSRRW || op == exu_ctrl_pkg::OP_CSRRS;
    assign is_ecall  = op == exu_ctrl_pkg::OP_ECALL;

    // csrrs sets bits, csrrw replaces
    assign csr_wdata = (op == exu_ctrl_pkg::OP_CSRRS) ? (csr_rdata | operand_a) : operand_a;

    // ******************************************************************
    // write side, commits at the next edge
    // ******************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
            mstatus <= MSTATUS_INIT;
        end else begin
            if (csr_write && csr_addr == riscv_isa_pkg::CSR_MTVEC)
                mtvec <= csr_wdata;
            if (csr_write && csr_addr == riscv_isa_pkg::CSR_MSTATUS)
                mstatus <= csr_wdata;
            // ecall saves the trap pc and cause
            if (is_ecall) begin
                mepc   <= pc;
                mcause <= riscv_isa_pkg::MCAUSE_ECALL_M;
            end else begin
                if (csr_write && csr_addr == riscv_isa_pkg::CSR_MEPC)
                    mepc <= csr_wdata;
                if (csr_write && csr_addr == riscv_isa_pkg::CSR_MCAUSE)
                    mcause <= csr_wdata;
            end
        end
    end

    // held reset keeps every csr frozen
    a_frozen_in_reset: assert property (
        @(posedge clk) rst && $past(rst) |=> $stable({mtvec, mepc, mcause, mstatus})
    );

endmodule

/* logic/exu_ctrl_pkg.sv */
package exu_ctrl_pkg;

    // ******************************************************************
    // operation class, picked by the decoder
    // ******************************************************************
    // OP_NONE must stay zero, it marks an empty slot
    typedef enum logic [4:0] {
        OP_NONE,
        OP_ALU,
        OP_ALU_W,
        OP_LUI,
        OP_JAL,
        OP_JALR,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_CSRRW,
        OP_CSRRS,
        OP_ECALL,
        OP_MRET
    } exu_op_e;

    // alu function, codes as used by the decoder
    typedef enum logic [7:0] {
        ALU_ADD  = 8'd0,
        ALU_SUB  = 8'd1,
        ALU_SLT  = 8'd2,
        ALU_SLTU = 8'd3,
        ALU_AND  = 8'd4,
        ALU_OR   = 8'd6,
        ALU_XOR  = 8'd7,
        ALU_SLL  = 8'd8,
        ALU_SRL  = 8'd9,
        ALU_SRA  = 8'd10
    } alu_mode_e;

endpackage

/* logic/exu_issue_reg.sv */
module exu_issue_reg (
    input  logic                      clk,
    input  logic                      rst,
    input  exu_ctrl_pkg::exu_op_e     op_in,
    input  exu_ctrl_pkg::alu_mode_e   alu_mode_in,
    input  riscv_isa_pkg::inst_t      inst_in,
    input  riscv_isa_pkg::xlen_t      pc_in,
    input  riscv_isa_pkg::xlen_t      operand_a_in,
    input  riscv_isa_pkg::xlen_t      operand_b_in,
    output exu_ctrl_pkg::exu_op_e     op,
    output exu_ctrl_pkg::alu_mode_e   alu_mode,
    output riscv_isa_pkg::inst_t      inst,
    output riscv_isa_pkg::xlen_t      pc,
    output riscv_isa_pkg::xlen_t      operand_a,
    output riscv_isa_pkg::xlen_t      operand_b,
    output riscv_isa_pkg::xlen_t      imm_u,
    output riscv_isa_pkg::xlen_t      imm_b,
    output riscv_isa_pkg::reg_idx_t   rd,
    output riscv_isa_pkg::csr_addr_t  csr_addr
);

    logic                  valid;
    exu_ctrl_pkg::exu_op_e op_q;

    // stage register, one new instruction every edge
    always_ff @(posedge clk) begin
        if (rst) begin
            valid     <= 1'b0;
            op_q      <= exu_ctrl_pkg::OP_NONE;
            alu_mode  <= exu_ctrl_pkg::ALU_ADD;
            inst      <= '0;
            pc        <= '0;
            operand_a <= '0;
            operand_b <= '0;
        end else begin
            valid     <= 1'b1;
            op_q      <= op_in;
            alu_mode  <= alu_mode_in;
            inst      <= inst_in;
            pc        <= pc_in;
            operand_a <= operand_a_in;
            operand_b <= operand_b_in;
        end
    end

    // empty slot until the first real instruction lands
    assign op = valid ? op_q : exu_ctrl_pkg::OP_NONE;

    // field decode
    assign rd       = inst[11:7];
    assign csr_addr = inst[31:20];
    assign imm_u    = {{32{inst[31]}}, inst[31:12], 12'b0};
    // b-type, offset in units of two bytes
    assign imm_b    = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    // first cycle out of reset must not retire anything
    a_idle_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> op == exu_ctrl_pkg::OP_NONE
    );

endmodule

/* logic/exu_top.sv */
module exu_top #(
    parameter riscv_isa_pkg::xlen_t MSTATUS_INIT = riscv_isa_pkg::MSTATUS_RESET
) (
    input  logic                     clk,
    input  logic                     rst,
    input  exu_ctrl_pkg::exu_op_e    op,
    input  exu_ctrl_pkg::alu_mode_e  alu_mode,
    input  riscv_isa_pkg::inst_t     inst,
    input  riscv_isa_pkg::xlen_t     pc,
    input  riscv_isa_pkg::xlen_t     operand_a,
    input  riscv_isa_pkg::xlen_t     operand_b,
    output riscv_isa_pkg::xlen_t     dnpc,
    output riscv_isa_pkg::xlen_t     pc_wb,
    output riscv_isa_pkg::xlen_t     reg_wdata,
    output riscv_isa_pkg::inst_t     inst_wb,
    output logic                     pc_update,
    output logic                     reg_wen,
    output riscv_isa_pkg::reg_idx_t  reg_idx
);

    // registered stage state
    exu_ctrl_pkg::exu_op_e     ex_op;
    exu_ctrl_pkg::alu_mode_e   ex_alu_mode;
    riscv_isa_pkg::xlen_t      ex_operand_a;
    riscv_isa_pkg::xlen_t      ex_operand_b;
    riscv_isa_pkg::xlen_t      ex_imm_u;
    riscv_isa_pkg::xlen_t      ex_imm_b;
    riscv_isa_pkg::reg_idx_t   ex_rd;
    riscv_isa_pkg::csr_addr_t  ex_csr_addr;
    // combinational results
    riscv_isa_pkg::xlen_t      alu_result;
    riscv_isa_pkg::xlen_t      csr_rdata;
    riscv_isa_pkg::xlen_t      mtvec;
    riscv_isa_pkg::xlen_t      mepc;

    // pc and inst go out unchanged as pc_wb / inst_wb
    exu_issue_reg i_issue_reg (
        .clk(clk), .rst(rst),
        .op_in(op), .alu_mode_in(alu_mode), .inst_in(inst),
        .pc_in(pc), .operand_a_in(operand_a), .operand_b_in(operand_b),
        .op(ex_op), .alu_mode(ex_alu_mode), .inst(inst_wb), .pc(pc_wb),
        .operand_a(ex_operand_a), .operand_b(ex_operand_b),
        .imm_u(ex_imm_u), .imm_b(ex_imm_b), .rd(ex_rd), .csr_addr(ex_csr_addr)
    );

    exu_alu i_alu (
        .alu_mode(ex_alu_mode), .operand_a(ex_operand_a),
        .operand_b(ex_operand_b), .result(alu_result)
    );

    exu_branch i_branch (
        .op(ex_op), .pc(pc_wb), .imm_b(ex_imm_b), .alu_result(alu_result),
        .mtvec(mtvec), .mepc(mepc), .dnpc(dnpc), .pc_update(pc_update)
    );

    exu_csr_file #(.MSTATUS_INIT(MSTATUS_INIT)) i_csr_file (
        .clk(clk), .rst(rst), .op(ex_op), .csr_addr(ex_csr_addr),
        .pc(pc_wb), .operand_a(ex_operand_a),
        .csr_rdata(csr_rdata), .mtvec(mtvec), .mepc(mepc)
    );

    exu_writeback i_writeback (
        .op(ex_op), .rd(ex_rd), .pc(pc_wb), .imm_u(ex_imm_u),
        .alu_result(alu_result), .csr_rdata(csr_rdata),
        .reg_wen(reg_wen), .reg_idx(reg_idx), .reg_wdata(reg_wdata)
    );

endmodule

/* logic/exu_writeback.sv */
module exu_writeback (
    input  exu_ctrl_pkg::exu_op_e    op,
    input  riscv_isa_pkg::reg_idx_t  rd,
    input  riscv_isa_pkg::xlen_t     pc,
    input  riscv_isa_pkg::xlen_t     imm_u,
    input  riscv_isa_pkg::xlen_t     alu_result,
    input  riscv_isa_pkg::xlen_t     csr_rdata,
    output logic                     reg_wen,
    output riscv_isa_pkg::reg_idx_t  reg_idx,
    output riscv_isa_pkg::xlen_t     reg_wdata
);

    riscv_isa_pkg::xlen_t link;
    riscv_isa_pkg::xlen_t word_ext;

    // return address for jal/jalr
    assign link     = pc + riscv_isa_pkg::INST_BYTES;
    // *w ops, low word sign extended
    assign word_ext = {{32{alu_result[31]}}, alu_result[31:0]};

    // x0 writes pass through, the regfile drops them
    assign reg_idx = rd;

    always_comb begin
        reg_wen = 1'b1;
        case (op)
            exu_ctrl_pkg::OP_ALU:   reg_wdata = alu_result;
            exu_ctrl_pkg::OP_ALU_W: reg_wdata = word_ext;
            exu_ctrl_pkg::OP_LUI:   reg_wdata = imm_u;
            exu_ctrl_pkg::OP_JAL,
            exu_ctrl_pkg::OP_JALR:  reg_wdata = link;
            // rd gets the old csr value
            exu_ctrl_pkg::OP_CSRRW,
            exu_ctrl_pkg::OP_CSRRS: reg_wdata = csr_rdata;
            default: begin
                reg_wen   = 1'b0;
                reg_wdata = '0;
            end
        endcase
    end

endmodule

/* logic/riscv_isa_pkg.sv */
package riscv_isa_pkg;

    // ******************************************************************
    // machine word and instruction field widths
    // ******************************************************************
    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [11:0]     csr_addr_t;

    // machine-mode csr addresses
    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;

    // environment call from m-mode
    localparam xlen_t MCAUSE_ECALL_M = 64'd11;

    // mpp = machine, sxl/uxl = 64 bit
    localparam xlen_t MSTATUS_RESET = 64'h0000_000a_0000_1800;

    // fixed instruction size, no compressed set
    localparam xlen_t INST_BYTES = 64'd4;

endpackage
